/* tests/serpentPatterns.hex */
// entries 0 to 32: subkeys 0 to 32 in the standard domain, as the core takes them
// entries 33 to 38: plaintexts, entry 39: ciphertext of the first plaintext
DDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDD
55555555555555555555555555555555
CCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCC
00000000000000000000000000000000
55555555555555555555555555555555
88888888888888888888888888888888
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
33333333333333333333333333333333
DDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDD
55555555555555555555555555555555
CCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCC
00000000000000000000000000000000
55555555555555555555555555555555
88888888888888888888888888888888
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
33333333333333333333333333333333
DDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDD
55555555555555555555555555555555
CCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCC
00000000000000000000000000000000
55555555555555555555555555555555
88888888888888888888888888888888
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
33333333333333333333333333333333
DDDDDDDDDDDDDDDDDDDDDDDDDDDDDDDD
55555555555555555555555555555555
CCCCCCCCCCCCCCCCCCCCCCCCCCCCCCCC
00000000000000000000000000000000
55555555555555555555555555555555
88888888888888888888888888888888
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
33333333333333333333333333333333
0123456789ABCDEF0123456789ABCDEF
// plaintexts
00000000000000000000000000000000
80000000000000000000000000000000
0123456789ABCDEFFEDCBA9876543210
3243F6A8885A308D313198A2E0370734
00112233445566778899AABBCCDDEEFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
// zero plaintext meets each box at its zero input, so only subkey 32 shows
00FF00FF0F0F0F0F3333333355555555

/* tb.f */
common/serpentPkg.sv
logic/sboxLayer.sv
rounds/serpentRound.sv
logic/keyStore.sv
logic/blockIngress.sv
logic/blockEgress.sv
logic/serpentCore.sv
tests/serpentTb.sv

/* tests/serpentTb.sv */
`timescale 1ns/1ps

module serpentTb;

	logic clk;
	logic reset;
	logic keyWrite;
	logic [5:0] keyIndex;
	logic [127:0] keyData;
	logic inStrobe;
	logic [127:0] plaintext;
	logic outStrobe;
	logic [127:0] ciphertext;

	logic [127:0] patterns [0:39]; // 33 subkeys, 6 plaintexts, 1 known answer
	logic [127:0] modelKeys [0:32];
	logic [127:0] expectQueue [$];
	time sendTimes [$];
	logic [127:0] lastCipher;
	int errorCount;
	int testStartErrors;
	int passCount;
	int failCount;
	int sendCount;
	int recvCount;

	serpentCore serpentCore_inst
	(
		.clk(clk),
		.reset(reset),
		.keyWrite(keyWrite),
		.keyIndex(keyIndex),
		.keyData(keyData),
		.inStrobe(inStrobe),
		.plaintext(plaintext),
		.outStrobe(outStrobe),
		.ciphertext(ciphertext)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] rotl32(input logic [31:0] word, input int amount);
		return (word << amount) | (word >> (32 - amount));
	endfunction

	// box n, entry v sits at bits 4v+3..4v
	function automatic logic [63:0] boxRow(input int box);
		case (box)
			0: return 64'hC90724DEB56A1F83;
			1: return 64'h43D68EB1A50972CF;
			2: return 64'h25B04E1DFAC39768;
			3: return 64'hE57A421D369C8BF0;
			4: return 64'hD7E9A4526B0C38F1;
			5: return 64'h176D8E30C9A4B25F;
			6: return 64'h0A3DF19EB6485C27;
			default: return 64'h6539AC47B28E0FD1;
		endcase
	endfunction

	// word b of a standard-domain subkey in bitslice form
	function automatic logic [31:0] keySlice(input logic [127:0] key, input int b);
		logic [31:0] w;
		for (int n = 0; n < 32; n++)
			w[n] = key[4 * n + b];
		return w;
	endfunction

	// bitslice reference encryption with the subkeys the host has written
	function automatic logic [127:0] encryptModel(input logic [127:0] pt);
		logic [31:0] x0;
		logic [31:0] x1;
		logic [31:0] x2;
		logic [31:0] x3;
		logic [63:0] row;
		logic [3:0] column;
		logic [3:0] s;
		x0 = pt[31:0];
		x1 = pt[63:32];
		x2 = pt[95:64];
		x3 = pt[127:96];
		for (int r = 0; r < 32; r++)
		begin
			x0 = x0 ^ keySlice(modelKeys[r], 0);
			x1 = x1 ^ keySlice(modelKeys[r], 1);
			x2 = x2 ^ keySlice(modelKeys[r], 2);
			x3 = x3 ^ keySlice(modelKeys[r], 3);
			row = boxRow(r % 8);
			for (int n = 0; n < 32; n++)
			begin
				column = {x3[n], x2[n], x1[n], x0[n]};
				s = row[4 * column +: 4];
				{x3[n], x2[n], x1[n], x0[n]} = s;
			end
			if (r < 31)
			begin
				x0 = rotl32(x0, 13);
				x2 = rotl32(x2, 3);
				x1 = x1 ^ x0 ^ x2;
				x3 = x3 ^ x2 ^ (x0 << 3);
				x1 = rotl32(x1, 1);
				x3 = rotl32(x3, 7);
				x0 = x0 ^ x1 ^ x3;
				x2 = x2 ^ x3 ^ (x1 << 7);
				x0 = rotl32(x0, 5);
				x2 = rotl32(x2, 22);
			end
			else
			begin
				x0 = x0 ^ keySlice(modelKeys[32], 0); // output whitening
				x1 = x1 ^ keySlice(modelKeys[32], 1);
				x2 = x2 ^ keySlice(modelKeys[32], 2);
				x3 = x3 ^ keySlice(modelKeys[32], 3);
			end
		end
		return {x3, x2, x1, x0};
	endfunction

	task automatic writeKey(input int index, input logic [127:0] data);
		@(posedge clk);
		keyWrite <= 1'b1;
		keyIndex <= 6'(index);
		keyData <= data;
		if (index < 33)
			modelKeys[index] = data; // store has no slot past 32
		@(posedge clk);
		keyWrite <= 1'b0;
	endtask

	task automatic sendBlock(input logic [127:0] pt);
		@(posedge clk);
		inStrobe <= 1'b1;
		plaintext <= pt;
		expectQueue.push_back(encryptModel(pt));
		sendTimes.push_back($time);
		sendCount++;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			inStrobe <= 1'b0;
		end
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		while (expectQueue.size() != 0 && waited < 200)
		begin
			@(posedge clk);
			waited++;
		end
		if (expectQueue.size() != 0)
		begin
			$display("timeout: %0d blocks still in flight 200 cycles later, at %0t",
				expectQueue.size(), $time);
			errorCount++;
			expectQueue.delete();
			sendTimes.delete();
		end
	endtask

	task automatic finishTest(input int number, input string name);
		int found;
		found = errorCount - testStartErrors;
		if (found == 0)
		begin
			passCount++;
			$display("test %0d, %s: ok", number, name);
		end
		else
		begin
			failCount++;
			$display("test %0d, %s: %0d errors", number, name, found);
		end
	endtask

	// outputs change at the rising edge, so look at them half a cycle later
	always @(negedge clk)
	begin : outputMonitor
		logic [127:0] expected;
		time sentAt;
		if (reset === 1'b0 && outStrobe !== 1'b0 && outStrobe !== 1'b1)
		begin
			$display("output strobe is unknown after reset at %0t", $time);
			errorCount++;
		end
		if (outStrobe === 1'b1)
		begin
			if (expectQueue.size() == 0)
			begin
				$display("unexpected output strobe with no block in flight at %0t", $time);
				errorCount++;
			end
			else
			begin
				expected = expectQueue.pop_front();
				sentAt = sendTimes.pop_front();
				recvCount++;
				lastCipher = ciphertext;
				if (ciphertext !== expected)
				begin
					$display("error at %0t: ciphertext expected %h, got %h",
						$time, expected, ciphertext);
					errorCount++;
				end
				if (($time - sentAt) / 8 != 33)
				begin
					$display("error at %0t: latency expected 33 cycles, got %0d",
						$time, ($time - sentAt) / 8);
					errorCount++;
				end
			end
		end
	end

	initial
	begin
		int gap;
		int sentBefore;
		int recvBefore;
		logic [127:0] goodCipher;
		void'($urandom(32'h43ef));
		clk = 1'b0;
		reset = 1'b1;
		keyWrite = 1'b0;
		keyIndex = '0;
		keyData = '0;
		inStrobe = 1'b0;
		plaintext = '0;
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		sendCount = 0;
		recvCount = 0;
		for (int k = 0; k < 33; k++)
			modelKeys[k] = '0;
		$readmemh("tests/serpentPatterns.hex", patterns);
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		testStartErrors = errorCount;
		idle(50);
		finishTest(1, "quiet after reset");

		testStartErrors = errorCount;
		for (int k = 0; k < 33; k++)
			writeKey(k, patterns[k]);
		if (encryptModel(patterns[33]) !== patterns[39])
		begin
			$display("error at %0t: reference model gives %h, known answer is %h",
				$time, encryptModel(patterns[33]), patterns[39]);
			errorCount++;
		end
		for (int v = 0; v < 6; v++)
		begin
			sendBlock(patterns[33 + v]);
			idle(1);
			waitDrain();
		end
		finishTest(2, "single blocks");

		testStartErrors = errorCount;
		for (int v = 0; v < 6; v++)
			sendBlock(patterns[33 + v]); // back to back
		idle(1);
		waitDrain();
		finishTest(3, "back-to-back blocks");

		testStartErrors = errorCount;
		sentBefore = sendCount;
		recvBefore = recvCount;
		for (int i = 0; i < 40; i++)
		begin
			sendBlock(patterns[33 + i % 6]);
			gap = $urandom % 4;
			idle(gap);
		end
		idle(1);
		waitDrain();
		if (recvCount - recvBefore != sendCount - sentBefore)
		begin
			$display("output count %0d does not match input count %0d",
				recvCount - recvBefore, sendCount - sentBefore);
			errorCount++;
		end
		finishTest(4, "random gaps");

		testStartErrors = errorCount;
		goodCipher = encryptModel(patterns[34]);
		writeKey(40, ~patterns[8]); // would land on subkey 8 if the index wrapped
		sendBlock(patterns[34]);
		idle(1);
		waitDrain();
		writeKey(0, patterns[0] ^ 128'h1);
		sendBlock(patterns[34]);
		idle(1);
		waitDrain();
		if (lastCipher === goodCipher)
		begin
			$display("error at %0t: ciphertext %h unchanged after subkey 0 changed",
				$time, lastCipher);
			errorCount++;
		end
		writeKey(0, patterns[0]);
		sendBlock(patterns[34]);
		idle(1);
		waitDrain();
		finishTest(5, "subkey writes");

		$display("summary: %0d tests ok, %0d tests with errors, %0d errors in total",
			passCount, failCount, errorCount);
		if (errorCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* logic/serpentCore.sv */
`timescale 1ns/1ps

module serpentCore
(
	input logic clk,
	input logic reset,
	input logic keyWrite,
	input logic [serpentPkg::keyIndexWidth-1:0] keyIndex,
	input logic [serpentPkg::blockWidth-1:0] keyData,
	input logic inStrobe,
	input logic [serpentPkg::blockWidth-1:0] plaintext,
	output logic outStrobe,
	output logic [serpentPkg::blockWidth-1:0] ciphertext
);

	import serpentPkg::*;

	logic [subkeyCount*blockWidth-1:0] roundKeys;
	logic stageValid [roundCount]; // stage k feeds round k, stage 31 feeds egress
	logic [blockWidth-1:0] stageBlock [roundCount];

	keyStore keyStore_inst
	(
		.clk(clk),
		.reset(reset),
		.keyWrite(keyWrite),
		.keyIndex(keyIndex),
		.keyData(keyData),
		.roundKeys(roundKeys)
	);

	blockIngress blockIngress_inst
	(
		.clk(clk),
		.reset(reset),
		.inStrobe(inStrobe),
		.plaintext(plaintext),
		.outValid(stageValid[0]),
		.outBlock(stageBlock[0])
	);

	for (genvar r = 0; r < roundCount - 1; r++)
	begin : roundStage
		serpentRound #(.roundIndex(r)) serpentRound_inst
		(
			.clk(clk),
			.reset(reset),
			.inValid(stageValid[r]),
			.inBlock(stageBlock[r]),
			.roundKey(roundKeys[r*blockWidth +: blockWidth]),
			.outValid(stageValid[r+1]),
			.outBlock(stageBlock[r+1])
		);
	end

	blockEgress blockEgress_inst
	(
		.clk(clk),
		.reset(reset),
		.inValid(stageValid[roundCount-1]),
		.inBlock(stageBlock[roundCount-1]),
		.lastKey(roundKeys[(roundCount-1)*blockWidth +: blockWidth]),
		.whiteKey(roundKeys[roundCount*blockWidth +: blockWidth]), // subkey 32
		.outStrobe(outStrobe),
		.ciphertext(ciphertext)
	);

endmodule

/* logic/blockEgress.sv */
`timescale 1ns/1ps

module blockEgress
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic [serpentPkg::blockWidth-1:0] inBlock,
	input logic [serpentPkg::blockWidth-1:0] lastKey,
	input logic [serpentPkg::blockWidth-1:0] whiteKey,
	output logic outStrobe,
	output logic [serpentPkg::blockWidth-1:0] ciphertext
);

	import serpentPkg::*;

	localparam logic [2:0] lastBox = 3'((roundCount - 1) % 8);

	logic [blockWidth-1:0] keyed;
	logic [blockWidth-1:0] substituted;
	logic [blockWidth-1:0] whitened;

	assign keyed = inBlock ^ lastKey;

	sboxLayer sboxLayer_inst
	(
		.select(lastBox),
		.inData(keyed),
		.outData(substituted)
	);

	assign whitened = substituted ^ whiteKey; // last round has no linear transform

	always_ff @(posedge clk)
	begin
		if (reset)
			outStrobe <= 1'b0;
		else
			outStrobe <= inValid;
	end

	always_ff @(posedge clk)
	begin
		ciphertext <= finalPerm(whitened);
	end

endmodule

/* logic/blockIngress.sv */
`timescale 1ns/1ps

module blockIngress
(
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input logic [serpentPkg::blockWidth-1:0] plaintext,
	output logic outValid,
	output logic [serpentPkg::blockWidth-1:0] outBlock
);

	import serpentPkg::*;

	always_ff @(posedge clk)
	begin
		if (reset)
			outValid <= 1'b0;
		else
			outValid <= inStrobe; // head of the valid chain
	end

	always_ff @(posedge clk)
	begin
		outBlock <= initialPerm(plaintext); // rounds work in the standard domain
	end

endmodule

/* logic/keyStore.sv */
`timescale 1ns/1ps

module keyStore
(
	input logic clk,
	input logic reset,
	input logic keyWrite,
	input logic [serpentPkg::keyIndexWidth-1:0] keyIndex,
	input logic [serpentPkg::blockWidth-1:0] keyData,
	output logic [serpentPkg::subkeyCount*serpentPkg::blockWidth-1:0] roundKeys
);

	import serpentPkg::*;

	logic [blockWidth-1:0] subkeys [subkeyCount];
	logic indexValid;

	assign indexValid = keyIndex < subkeyCount; // indices past the last subkey are dropped

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int k = 0; k < subkeyCount; k++)
				subkeys[k] <= '0;
		end
		else if (keyWrite && indexValid)
			subkeys[keyIndex] <= keyData;
	end

	// subkey k sits at slice k of the flat bus
	for (genvar k = 0; k < subkeyCount; k++)
	begin : keySlice
		assign roundKeys[k*blockWidth +: blockWidth] = subkeys[k];
	end

endmodule

/* rounds/serpentRound.sv */
`timescale 1ns/1ps

module serpentRound
#(
	parameter int roundIndex = 0
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic [serpentPkg::blockWidth-1:0] inBlock,
	input logic [serpentPkg::blockWidth-1:0] roundKey,
	output logic outValid,
	output logic [serpentPkg::blockWidth-1:0] outBlock
);

	import serpentPkg::*;

	localparam logic [2:0] boxSelect = 3'(roundIndex % 8); // boxes repeat every eight rounds

	logic [blockWidth-1:0] keyed;
	logic [blockWidth-1:0] substituted;

	assign keyed = inBlock ^ roundKey;

	sboxLayer sboxLayer_inst
	(
		.select(boxSelect),
		.inData(keyed),
		.outData(substituted)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
			outValid <= 1'b0;
		else
			outValid <= inValid;
	end

	always_ff @(posedge clk)
	begin
		outBlock <= linearTransform(substituted);
	end

endmodule

/* logic/sboxLayer.sv */
`timescale 1ns/1ps

module sboxLayer
(
	input logic [2:0] select,
	input logic [serpentPkg::blockWidth-1:0] inData,
	output logic [serpentPkg::blockWidth-1:0] outData
);

	import serpentPkg::*;

	// eight boxes of sixteen entries, addressed by {box, nibble}
	localparam logic [3:0] boxTable [0:127] = '{
		4'h3, 4'h8, 4'hF, 4'h1,
		4'hA, 4'h6, 4'h5, 4'hB,
		4'hE, 4'hD, 4'h4, 4'h2,
		4'h7, 4'h0, 4'h9, 4'hC,

		4'hF, 4'hC, 4'h2, 4'h7,
		4'h9, 4'h0, 4'h5, 4'hA,
		4'h1, 4'hB, 4'hE, 4'h8,
		4'h6, 4'hD, 4'h3, 4'h4,

		4'h8, 4'h6, 4'h7, 4'h9,
		4'h3, 4'hC, 4'hA, 4'hF,
		4'hD, 4'h1, 4'hE, 4'h4,
		4'h0, 4'hB, 4'h5, 4'h2,

		4'h0, 4'hF, 4'hB, 4'h8,
		4'hC, 4'h9, 4'h6, 4'h3,
		4'hD, 4'h1, 4'h2, 4'h4,
		4'hA, 4'h7, 4'h5, 4'hE,

		4'h1, 4'hF, 4'h8, 4'h3,
		4'hC, 4'h0, 4'hB, 4'h6,
		4'h2, 4'h5, 4'h4, 4'hA,
		4'h9, 4'hE, 4'h7, 4'hD,

		4'hF, 4'h5, 4'h2, 4'hB,
		4'h4, 4'hA, 4'h9, 4'hC,
		4'h0, 4'h3, 4'hE, 4'h8,
		4'hD, 4'h6, 4'h7, 4'h1,

		4'h7, 4'h2, 4'hC, 4'h5,
		4'h8, 4'h4, 4'h6, 4'hB,
		4'hE, 4'h9, 4'h1, 4'hF,
		4'hD, 4'h3, 4'hA, 4'h0,

		4'h1, 4'hD, 4'hF, 4'h0,
		4'hE, 4'h8, 4'h2, 4'hB,
		4'h7, 4'h4, 4'hC, 4'hA,
		4'h9, 4'h3, 4'h5, 4'h6
	};

	always_comb
	begin
		for (int n = 0; n < blockWidth / 4; n++)
			outData[4*n +: 4] = boxTable[{select, inData[4*n +: 4]}]; // bit 4n is the nibble lsb
	end

endmodule

/* common/serpentPkg.sv */
package serpentPkg;

	localparam int blockWidth = 128;
	localparam int roundCount = 32;
	localparam int subkeyCount = 33;
	localparam int keyIndexWidth = 6;

	function automatic logic [31:0] rotateLeft(input logic [31:0] word, input int amount);
		return (word << amount) | (word >> (32 - amount));
	endfunction

	// bit j of the result takes bit (j%4)*32 + j/4 of the input
	function automatic logic [blockWidth-1:0] initialPerm(input logic [blockWidth-1:0] x);
		logic [blockWidth-1:0] y;
		for (int j = 0; j < blockWidth; j++)
			y[j] = x[(j % 4) * 32 + j / 4];
		return y;
	endfunction

	function automatic logic [blockWidth-1:0] finalPerm(input logic [blockWidth-1:0] x);
		logic [blockWidth-1:0] y;
		for (int j = 0; j < blockWidth; j++)
			y[j] = x[(j % 32) * 4 + j / 32];
		return y;
	endfunction

	// linear transform seen from the standard domain
	function automatic logic [blockWidth-1:0] linearTransform(input logic [blockWidth-1:0] x);
		logic [blockWidth-1:0] sliced;
		logic [31:0] x0;
		logic [31:0] x1;
		logic [31:0] x2;
		logic [31:0] x3;
		sliced = finalPerm(x);
		x0 = sliced[31:0]; // least significant word
		x1 = sliced[63:32];
		x2 = sliced[95:64];
		x3 = sliced[127:96];
		x0 = rotateLeft(x0, 13);
		x2 = rotateLeft(x2, 3);
		x1 = x1 ^ x0 ^ x2;
		x3 = x3 ^ x2 ^ (x0 << 3);
		x1 = rotateLeft(x1, 1);
		x3 = rotateLeft(x3, 7);
		x0 = x0 ^ x1 ^ x3;
		x2 = x2 ^ x3 ^ (x1 << 7);
		x0 = rotateLeft(x0, 5);
		x2 = rotateLeft(x2, 22);
		return initialPerm({x3, x2, x1, x0});
	endfunction

endpackage
